/* mips_pkg.sv */
package mips_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  cp0_addr_t;

   typedef enum logic [3:0] {
      OPER_ALUS = 4'd0, // signed alu
      OPER_ALUU = 4'd1, // unsigned alu
      OPER_MFHI = 4'd2,
      OPER_MFLO = 4'd3,
      OPER_MTHI = 4'd4,
      OPER_MTLO = 4'd5,
      OPER_MFC0 = 4'd6,
      OPER_MTC0 = 4'd7,
      OPER_NOP  = 4'd8
   } oper_t;

   typedef enum logic [4:0] {
      FUNC_NONE = 5'd0, // also means no mulalu request
      FUNC_AND  = 5'd1,
      FUNC_OR   = 5'd2,
      FUNC_XOR  = 5'd3,
      FUNC_NOR  = 5'd4,
      FUNC_LUI  = 5'd5,
      FUNC_SLL  = 5'd6,
      FUNC_SRL  = 5'd7,
      FUNC_SRA  = 5'd8,
      FUNC_ADD  = 5'd9,
      FUNC_SUB  = 5'd10,
      FUNC_SLT  = 5'd11,
      FUNC_MUL  = 5'd12,
      FUNC_DIV  = 5'd13
   } func_t;

   localparam cp0_addr_t CP0_COUNT  = 5'd9;
   localparam cp0_addr_t CP0_STATUS = 5'd12;
   localparam cp0_addr_t CP0_CAUSE  = 5'd13;
   localparam cp0_addr_t CP0_EPC    = 5'd14;

   typedef struct packed {
      oper_t     oper;
      func_t     func;
      word_t     source_a;
      word_t     source_b;
      cp0_addr_t cp0_addr;
   } exec_req_t;

   typedef struct packed {
      logic  sign;
      func_t func;
      word_t source_a;
      word_t source_b;
   } mul_req_t;

   typedef struct packed {
      logic  en;
      word_t data;
   } hilo_wr_t;

   typedef struct packed {
      logic      en;
      cp0_addr_t addr;
      word_t     data;
   } cp0_wr_t;

endpackage

/* sglalu.sv */
`timescale 1ns/1ps

module sglalu (
   input  mips_pkg::exec_req_t req,
   input  mips_pkg::word_t     hi,
   input  mips_pkg::word_t     lo,
   input  mips_pkg::word_t     cp0_rd_data,
   output mips_pkg::word_t     result,
   output logic                ov,
   output mips_pkg::mul_req_t  mul_req,
   output mips_pkg::hilo_wr_t  hi_wr,
   output mips_pkg::hilo_wr_t  lo_wr,
   output mips_pkg::cp0_wr_t   cp0_wr
);

   mips_pkg::word_t a;
   mips_pkg::word_t b;
   mips_pkg::word_t add_res;
   mips_pkg::word_t sub_res;
   mips_pkg::word_t alu_res;
   logic [4:0]      shamt;
   logic            is_alu;
   logic            signed_op;
   logic            slt_bit;
   logic            add_ov;
   logic            sub_ov;

   assign a       = req.source_a;
   assign b       = req.source_b;
   assign shamt   = b[4:0];
   assign add_res = a + b;
   assign sub_res = a - b;

   assign is_alu    = (req.oper == mips_pkg::OPER_ALUS) || (req.oper == mips_pkg::OPER_ALUU);
   assign signed_op = (req.oper == mips_pkg::OPER_ALUS);
   assign slt_bit   = signed_op ? ($signed(a) < $signed(b)) : (a < b);

   // overflow when both operands agree in sign and the result does not
   assign add_ov = (a[31] == b[31]) && (add_res[31] != a[31]);
   assign sub_ov = (a[31] != b[31]) && (sub_res[31] != a[31]);
   assign ov     = signed_op &&
                   (((req.func == mips_pkg::FUNC_ADD) && add_ov) ||
                    ((req.func == mips_pkg::FUNC_SUB) && sub_ov));

   always_comb begin
      case (req.func)
         mips_pkg::FUNC_AND: alu_res = a & b;
         mips_pkg::FUNC_OR:  alu_res = a | b;
         mips_pkg::FUNC_XOR: alu_res = a ^ b;
         mips_pkg::FUNC_NOR: alu_res = ~(a | b);
         mips_pkg::FUNC_LUI: alu_res = b;               // decode already shifted the immediate
         mips_pkg::FUNC_SLL: alu_res = a << shamt;
         mips_pkg::FUNC_SRL: alu_res = a >> shamt;
         mips_pkg::FUNC_SRA: alu_res = $signed(a) >>> shamt;
         mips_pkg::FUNC_ADD: alu_res = add_res;
         mips_pkg::FUNC_SUB: alu_res = sub_res;
         mips_pkg::FUNC_SLT: alu_res = {31'b0, slt_bit};
         default:            alu_res = '0;              // mul/div land in hi/lo
      endcase
   end

   always_comb begin
      case (req.oper)
         mips_pkg::OPER_ALUS,
         mips_pkg::OPER_ALUU: result = alu_res;
         mips_pkg::OPER_MFHI: result = hi;
         mips_pkg::OPER_MFLO: result = lo;
         mips_pkg::OPER_MFC0: result = cp0_rd_data;
         default:             result = '0;
      endcase
   end

   always_comb begin
      mul_req.sign     = signed_op;
      mul_req.func     = mips_pkg::FUNC_NONE;
      mul_req.source_a = a;
      mul_req.source_b = b;
      if (is_alu && ((req.func == mips_pkg::FUNC_MUL) || (req.func == mips_pkg::FUNC_DIV))) begin
         mul_req.func = req.func;
      end
   end

   always_comb begin
      hi_wr.en     = (req.oper == mips_pkg::OPER_MTHI);
      hi_wr.data   = a;
      lo_wr.en     = (req.oper == mips_pkg::OPER_MTLO);
      lo_wr.data   = a;
      cp0_wr.en    = (req.oper == mips_pkg::OPER_MTC0);
      cp0_wr.addr  = req.cp0_addr;
      cp0_wr.data  = a;
   end

endmodule

/* mulalu.sv */
`timescale 1ns/1ps

module mulalu (
   input  logic               clk,
   input  logic               rst,
   input  mips_pkg::mul_req_t mul_req,
   output mips_pkg::hilo_wr_t hi_res,
   output mips_pkg::hilo_wr_t lo_res,
   output logic               busy
);

   logic [5:0]      step;
   logic            res_en;
   logic            start;
   logic            last;
   logic            is_div;
   logic            neg_a;
   logic            neg_b;
   mips_pkg::word_t mag_a;
   mips_pkg::word_t mag_b;
   mips_pkg::word_t opnd;      // multiplicand or divisor magnitude
   mips_pkg::word_t acc_hi;    // partial product high or remainder
   mips_pkg::word_t acc_lo;    // multiplier bits or quotient
   mips_pkg::word_t res_hi;
   mips_pkg::word_t res_lo;
   mips_pkg::word_t quot;
   mips_pkg::word_t rem;
   logic [32:0]     add_sum;
   logic [32:0]     div_shift;
   logic [33:0]     sub_diff;
   logic [63:0]     prod;

   assign start = !busy &&
                  ((mul_req.func == mips_pkg::FUNC_MUL) || (mul_req.func == mips_pkg::FUNC_DIV));
   assign last  = busy && (step == 6'd32);

   assign mag_a = (mul_req.sign && mul_req.source_a[31]) ? -mul_req.source_a : mul_req.source_a;
   assign mag_b = (mul_req.sign && mul_req.source_b[31]) ? -mul_req.source_b : mul_req.source_b;

   // one shift-add step
   assign add_sum = {1'b0, acc_hi} + (acc_lo[0] ? {1'b0, opnd} : 33'd0);

   // one restoring-subtract step, negative diff keeps the shifted remainder
   assign div_shift = {acc_hi, acc_lo[31]};
   assign sub_diff  = {1'b0, div_shift} - {2'b00, opnd};

   // sign correction on the finished magnitudes
   assign prod = (neg_a ^ neg_b) ? -{acc_hi, acc_lo} : {acc_hi, acc_lo};
   assign quot = (neg_a ^ neg_b) ? -acc_lo : acc_lo;
   assign rem  = neg_a ? -acc_hi : acc_hi;   // remainder follows the dividend

   always_ff @(posedge clk) begin
      if (rst) begin
         busy   <= 1'b0;
         step   <= '0;
         res_en <= 1'b0;
      end else begin
         res_en <= last;
         if (start) begin
            busy <= 1'b1;
            step <= '0;
         end else if (last) begin
            busy <= 1'b0;
         end else if (busy) begin
            step <= step + 6'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         is_div <= (mul_req.func == mips_pkg::FUNC_DIV);
         neg_a  <= mul_req.sign && mul_req.source_a[31];
         neg_b  <= mul_req.sign && mul_req.source_b[31];
         opnd   <= mag_b;
         acc_hi <= '0;
         acc_lo <= mag_a;
      end else if (busy && !last) begin
         if (is_div) begin
            acc_hi <= sub_diff[33] ? div_shift[31:0] : sub_diff[31:0];
            acc_lo <= {acc_lo[30:0], ~sub_diff[33]};
         end else begin
            {acc_hi, acc_lo} <= {add_sum, acc_lo[31:1]};
         end
      end
      if (last) begin
         res_hi <= is_div ? rem : prod[63:32];
         res_lo <= is_div ? quot : prod[31:0];
      end
   end

   assign hi_res.en   = res_en;
   assign hi_res.data = res_hi;
   assign lo_res.en   = res_en;
   assign lo_res.data = res_lo;

endmodule

/* hilo_regs.sv */
`timescale 1ns/1ps

module hilo_regs (
   input  logic               clk,
   input  logic               rst,
   input  mips_pkg::hilo_wr_t hi_wr,
   input  mips_pkg::hilo_wr_t lo_wr,
   input  mips_pkg::hilo_wr_t hi_res,
   input  mips_pkg::hilo_wr_t lo_res,
   output mips_pkg::word_t    hi,
   output mips_pkg::word_t    lo
);

   mips_pkg::hilo_wr_t mv_wr  [2];
   mips_pkg::hilo_wr_t mul_wr [2];
   mips_pkg::word_t    q      [2];

   assign mv_wr[0]  = hi_wr;
   assign mv_wr[1]  = lo_wr;
   assign mul_wr[0] = hi_res;
   assign mul_wr[1] = lo_res;

   for (genvar i = 0; i < 2; i++) begin : g_reg
      always_ff @(posedge clk) begin
         if (rst) begin
            q[i] <= '0;
         end else if (mul_wr[i].en) begin
            q[i] <= mul_wr[i].data;   // mulalu completion wins
         end else if (mv_wr[i].en) begin
            q[i] <= mv_wr[i].data;
         end
      end
   end

   assign hi = q[0];
   assign lo = q[1];

endmodule

/* cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs #(
   parameter mips_pkg::word_t COUNT_STEP = 32'd1
) (
   input  logic                clk,
   input  logic                rst,
   input  mips_pkg::cp0_addr_t cp0_addr,
   input  mips_pkg::cp0_wr_t   cp0_wr,
   output mips_pkg::word_t     cp0_rd_data
);

   mips_pkg::word_t count;
   mips_pkg::word_t status;
   mips_pkg::word_t cause;
   mips_pkg::word_t epc;

   always_ff @(posedge clk) begin
      if (rst) begin
         count  <= '0;
         status <= '0;
         cause  <= '0;
         epc    <= '0;
      end else begin
         if (cp0_wr.en && (cp0_wr.addr == mips_pkg::CP0_COUNT)) begin
            count <= cp0_wr.data;   // a write replaces this cycle's tick
         end else begin
            count <= count + COUNT_STEP;
         end
         if (cp0_wr.en && (cp0_wr.addr == mips_pkg::CP0_STATUS)) begin
            status <= cp0_wr.data;
         end
         if (cp0_wr.en && (cp0_wr.addr == mips_pkg::CP0_CAUSE)) begin
            cause <= cp0_wr.data;
         end
         if (cp0_wr.en && (cp0_wr.addr == mips_pkg::CP0_EPC)) begin
            epc <= cp0_wr.data;
         end
      end
   end

   always_comb begin
      case (cp0_addr)
         mips_pkg::CP0_COUNT:  cp0_rd_data = count;
         mips_pkg::CP0_STATUS: cp0_rd_data = status;
         mips_pkg::CP0_CAUSE:  cp0_rd_data = cause;
         mips_pkg::CP0_EPC:    cp0_rd_data = epc;
         default:              cp0_rd_data = '0;   // unimplemented numbers read zero
      endcase
   end

endmodule

/* exec_unit.sv */
`timescale 1ns/1ps

module exec_unit #(
   parameter mips_pkg::word_t COUNT_STEP = 32'd1
) (
   input  logic                clk,
   input  logic                rst,
   input  mips_pkg::exec_req_t req,
   output mips_pkg::word_t     result,
   output logic                ov,
   output logic                busy
);

   mips_pkg::mul_req_t mul_req;
   mips_pkg::hilo_wr_t hi_wr;
   mips_pkg::hilo_wr_t lo_wr;
   mips_pkg::hilo_wr_t hi_res;
   mips_pkg::hilo_wr_t lo_res;
   mips_pkg::cp0_wr_t  cp0_wr;
   mips_pkg::word_t    hi;
   mips_pkg::word_t    lo;
   mips_pkg::word_t    cp0_rd_data;

   sglalu u_sglalu (
      .req         (req),
      .hi          (hi),
      .lo          (lo),
      .cp0_rd_data (cp0_rd_data),
      .result      (result),
      .ov          (ov),
      .mul_req     (mul_req),
      .hi_wr       (hi_wr),
      .lo_wr       (lo_wr),
      .cp0_wr      (cp0_wr)
   );

   mulalu u_mulalu (
      .clk     (clk),
      .rst     (rst),
      .mul_req (mul_req),
      .hi_res  (hi_res),
      .lo_res  (lo_res),
      .busy    (busy)
   );

   hilo_regs u_hilo_regs (
      .clk    (clk),
      .rst    (rst),
      .hi_wr  (hi_wr),
      .lo_wr  (lo_wr),
      .hi_res (hi_res),
      .lo_res (lo_res),
      .hi     (hi),
      .lo     (lo)
   );

   cp0_regs #(
      .COUNT_STEP (COUNT_STEP)
   ) u_cp0_regs (
      .clk         (clk),
      .rst         (rst),
      .cp0_addr    (req.cp0_addr),   // read port follows the request
      .cp0_wr      (cp0_wr),
      .cp0_rd_data (cp0_rd_data)
   );

endmodule

/* tb_exec_unit.sv */
`timescale 1ns/1ps

module tb_exec_unit;

   localparam int              PERIOD      = 100;
   localparam mips_pkg::word_t COUNT_STEP  = 32'd3;
   // reset, reset check, logic/shift, add/sub, moves, 8 mul/div runs, cp0
   localparam int              TEST_CYCLES = 9 + 3 + 53 + 31 + 4 + 8 * 42 + 14;
   localparam int              MARGIN      = 150;
   localparam mips_pkg::func_t LOGIC_FUNCS [8] = '{
      mips_pkg::FUNC_AND, mips_pkg::FUNC_OR, mips_pkg::FUNC_XOR, mips_pkg::FUNC_NOR,
      mips_pkg::FUNC_LUI, mips_pkg::FUNC_SLL, mips_pkg::FUNC_SRL, mips_pkg::FUNC_SRA
   };

   logic                clk;
   logic                rst;
   mips_pkg::exec_req_t req;
   mips_pkg::word_t     result;
   logic                ov;
   logic                busy;
   mips_pkg::word_t     lfsr_state;
   mips_pkg::word_t     exp_hi;      // hi/lo as the testbench expects them
   mips_pkg::word_t     exp_lo;
   int                  checks;
   int                  errors;

   exec_unit #(
      .COUNT_STEP (COUNT_STEP)
   ) uut (
      .clk    (clk),
      .rst    (rst),
      .req    (req),
      .result (result),
      .ov     (ov),
      .busy   (busy)
   );

   always #(PERIOD / 2) clk = ~clk;

   function automatic mips_pkg::word_t lfsr_next(input mips_pkg::word_t s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic mips_pkg::word_t rand_word();
      mips_pkg::word_t w;
      w = '0;
      for (int i = 0; i < 32; i++) begin
         w          = {w[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return w;
   endfunction

   function automatic mips_pkg::word_t alu_model(input mips_pkg::oper_t oper,
                                                 input mips_pkg::func_t func,
                                                 input mips_pkg::word_t a,
                                                 input mips_pkg::word_t b);
      logic [4:0]      s;
      mips_pkg::word_t fill;
      mips_pkg::word_t res;
      s    = b[4:0];
      fill = a[31] ? ~(32'hffff_ffff >> s) : 32'h0;   // sign bits shifted in by sra
      case (func)
         mips_pkg::FUNC_AND: res = a & b;
         mips_pkg::FUNC_OR:  res = a | b;
         mips_pkg::FUNC_XOR: res = a ^ b;
         mips_pkg::FUNC_NOR: res = ~(a | b);
         mips_pkg::FUNC_LUI: res = b;
         mips_pkg::FUNC_SLL: res = a << s;
         mips_pkg::FUNC_SRL: res = a >> s;
         mips_pkg::FUNC_SRA: res = (a >> s) | fill;
         mips_pkg::FUNC_ADD: res = a + b;
         mips_pkg::FUNC_SUB: res = a - b;
         mips_pkg::FUNC_SLT: begin
            if (oper == mips_pkg::OPER_ALUS) begin
               res = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            end else begin
               res = {31'b0, a < b};
            end
         end
         default:            res = '0;
      endcase
      return res;
   endfunction

   function automatic logic ov_model(input mips_pkg::oper_t oper, input mips_pkg::func_t func,
                                     input mips_pkg::word_t a, input mips_pkg::word_t b);
      logic [32:0] s33;
      if (func == mips_pkg::FUNC_SUB) begin
         s33 = {a[31], a} - {b[31], b};
      end else begin
         s33 = {a[31], a} + {b[31], b};
      end
      return (oper == mips_pkg::OPER_ALUS) && (s33[32] != s33[31]) &&
             ((func == mips_pkg::FUNC_ADD) || (func == mips_pkg::FUNC_SUB));
   endfunction

   // returns {hi, lo}
   function automatic logic [63:0] muldiv_model(input logic sgn, input mips_pkg::func_t func,
                                                input mips_pkg::word_t a,
                                                input mips_pkg::word_t b);
      logic            neg_a;
      logic            neg_b;
      mips_pkg::word_t ma;
      mips_pkg::word_t mb;
      mips_pkg::word_t q;
      mips_pkg::word_t r;
      if (func == mips_pkg::FUNC_MUL) begin
         if (sgn) begin
            return {{32{a[31]}}, a} * {{32{b[31]}}, b};
         end
         return {32'b0, a} * {32'b0, b};
      end
      neg_a = sgn && a[31];
      neg_b = sgn && b[31];
      ma    = neg_a ? -a : a;
      mb    = neg_b ? -b : b;
      if (mb == 32'd0) begin
         q = '1;
         r = ma;
      end else begin
         q = ma / mb;
         r = ma % mb;
      end
      if (neg_a ^ neg_b) q = -q;
      if (neg_a) r = -r;
      return {r, q};
   endfunction

   task automatic check_word(input string name, input mips_pkg::word_t exp,
                             input mips_pkg::word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("MISMATCH time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      end
   endtask

   task automatic issue_op(input mips_pkg::oper_t oper, input mips_pkg::func_t func,
                           input mips_pkg::word_t a, input mips_pkg::word_t b,
                           input mips_pkg::cp0_addr_t addr);
      @(negedge clk);
      req.oper     = oper;
      req.func     = func;
      req.source_a = a;
      req.source_b = b;
      req.cp0_addr = addr;
      #10;   // combinational result settles well before the rising edge
   endtask

   task automatic run_alu(input mips_pkg::oper_t oper, input mips_pkg::func_t func,
                          input mips_pkg::word_t a, input mips_pkg::word_t b);
      issue_op(oper, func, a, b, '0);
      check_word({"result ", func.name()}, alu_model(oper, func, a, b), result);
      check_bit({"ov ", func.name()}, ov_model(oper, func, a, b), ov);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      if (errors == errors_before) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, errors - errors_before);
   endtask

   task automatic test_reset();
      int e0;
      e0 = errors;
      check_bit("busy", 1'b0, busy);
      issue_op(mips_pkg::OPER_MFHI, mips_pkg::FUNC_NONE, '0, '0, '0);
      check_word("hi", 32'd0, result);
      issue_op(mips_pkg::OPER_MFLO, mips_pkg::FUNC_NONE, '0, '0, '0);
      check_word("lo", 32'd0, result);
      issue_op(mips_pkg::OPER_MFC0, mips_pkg::FUNC_NONE, '0, '0, mips_pkg::CP0_STATUS);
      check_word("status", 32'd0, result);
      finish_test("reset", e0);
   endtask

   task automatic test_logic_shift();
      mips_pkg::word_t a;
      mips_pkg::word_t b;
      int              e0;
      e0 = errors;
      for (int i = 0; i < 6; i++) begin
         a = rand_word();
         b = rand_word();
         for (int j = 0; j < 8; j++) begin
            run_alu((i % 2 == 0) ? mips_pkg::OPER_ALUS : mips_pkg::OPER_ALUU,
                    LOGIC_FUNCS[j], a, b);
         end
      end
      a = rand_word() | 32'h8000_0000;   // negative for sra
      b = rand_word();
      run_alu(mips_pkg::OPER_ALUS, mips_pkg::FUNC_SRA, a, {b[31:5], 5'd0});
      run_alu(mips_pkg::OPER_ALUS, mips_pkg::FUNC_SRA, a, {b[31:5], 5'd31});
      run_alu(mips_pkg::OPER_ALUU, mips_pkg::FUNC_SRL, a, {b[31:5], 5'd31});
      run_alu(mips_pkg::OPER_ALUU, mips_pkg::FUNC_SLL, a, {b[31:5], 5'd31});
      run_alu(mips_pkg::OPER_ALUU, mips_pkg::FUNC_SLL, a, {b[31:5], 5'd0});
      finish_test("logic_shift", e0);
   endtask

   task automatic test_add_sub();
      mips_pkg::word_t a;
      mips_pkg::word_t b;
      int              e0;
      e0 = errors;
      for (int i = 0; i < 4; i++) begin
         a = rand_word();
         b = rand_word();
         run_alu(mips_pkg::OPER_ALUS, mips_pkg::FUNC_ADD, a, b);
         run_alu(mips_pkg::OPER_ALUU, mips_pkg::FUNC_ADD, a, b);
         run_alu(mips_pkg::OPER_ALUS, mips_pkg::FUNC_SUB, a, b);
         run_alu(mips_pkg::OPER_ALUU, mips_pkg::FUNC_SUB, a, b);
         run_alu(mips_pkg::OPER_ALUS, mips_pkg::FUNC_SLT, a, b);
         run_alu(mips_pkg::OPER_ALUU, mips_pkg::FUNC_SLT, a, b);
      end
      run_alu(mips_pkg::OPER_ALUS, mips_pkg::FUNC_ADD, 32'h7fff_ffff, 32'd1);
      run_alu(mips_pkg::OPER_ALUU, mips_pkg::FUNC_ADD, 32'h7fff_ffff, 32'd1);
      run_alu(mips_pkg::OPER_ALUS, mips_pkg::FUNC_SUB, 32'h8000_0000, 32'd1);
      run_alu(mips_pkg::OPER_ALUU, mips_pkg::FUNC_SUB, 32'h8000_0000, 32'd1);
      run_alu(mips_pkg::OPER_ALUS, mips_pkg::FUNC_ADD, 32'h8000_0000, 32'h8000_0000);
      run_alu(mips_pkg::OPER_ALUS, mips_pkg::FUNC_SLT, 32'hffff_ffff, 32'd1);
      run_alu(mips_pkg::OPER_ALUU, mips_pkg::FUNC_SLT, 32'hffff_ffff, 32'd1);
      finish_test("add_sub_slt", e0);
   endtask

   task automatic test_moves();
      int e0;
      e0     = errors;
      exp_hi = rand_word();
      exp_lo = rand_word();
      issue_op(mips_pkg::OPER_MTHI, mips_pkg::FUNC_NONE, exp_hi, '0, '0);
      issue_op(mips_pkg::OPER_MTLO, mips_pkg::FUNC_NONE, exp_lo, '0, '0);
      issue_op(mips_pkg::OPER_MFHI, mips_pkg::FUNC_NONE, '0, '0, '0);
      check_word("hi", exp_hi, result);
      issue_op(mips_pkg::OPER_MFLO, mips_pkg::FUNC_NONE, '0, '0, '0);
      check_word("lo", exp_lo, result);
      finish_test("hilo_moves", e0);
   endtask

   task automatic run_muldiv(input logic sgn, input mips_pkg::func_t func,
                             input mips_pkg::word_t a, input mips_pkg::word_t b);
      logic [63:0] exp;
      int          n;
      exp = muldiv_model(sgn, func, a, b);
      issue_op(sgn ? mips_pkg::OPER_ALUS : mips_pkg::OPER_ALUU, func, a, b, '0);
      issue_op(mips_pkg::OPER_MFHI, mips_pkg::FUNC_NONE, '0, '0, '0);
      check_bit("busy", 1'b1, busy);
      check_word("hi during busy", exp_hi, result);
      // must be dropped, the unit is still working
      issue_op(mips_pkg::OPER_ALUS, mips_pkg::FUNC_MUL, rand_word(), rand_word(), '0);
      issue_op(mips_pkg::OPER_NOP, mips_pkg::FUNC_NONE, '0, '0, '0);
      n = 0;
      while (busy && n < 40) begin
         @(negedge clk);
         #10;
         n++;
      end
      if (busy) begin
         errors++;
         $display("ERROR: busy still high 40 cycles after a %s request", func.name());
      end
      exp_hi = exp[63:32];
      exp_lo = exp[31:0];
      issue_op(mips_pkg::OPER_MFHI, mips_pkg::FUNC_NONE, '0, '0, '0);
      check_word({"hi after ", func.name()}, exp_hi, result);
      issue_op(mips_pkg::OPER_MFLO, mips_pkg::FUNC_NONE, '0, '0, '0);
      check_word({"lo after ", func.name()}, exp_lo, result);
   endtask

   task automatic test_muldiv();
      int e0;
      e0 = errors;
      run_muldiv(1'b1, mips_pkg::FUNC_MUL, rand_word(), rand_word());
      run_muldiv(1'b0, mips_pkg::FUNC_MUL, rand_word(), rand_word());
      run_muldiv(1'b0, mips_pkg::FUNC_MUL, 32'hffff_ffff, 32'hffff_ffff);
      run_muldiv(1'b1, mips_pkg::FUNC_DIV, rand_word(), rand_word() >> 16);
      run_muldiv(1'b0, mips_pkg::FUNC_DIV, rand_word(), rand_word() >> 12);
      run_muldiv(1'b1, mips_pkg::FUNC_DIV, 32'h8000_0000, 32'hffff_ffff);
      run_muldiv(1'b1, mips_pkg::FUNC_DIV, rand_word() | 32'h8000_0000, 32'd0);
      run_muldiv(1'b0, mips_pkg::FUNC_DIV, rand_word(), 32'd0);
      finish_test("mul_div", e0);
   endtask

   task automatic test_cp0();
      mips_pkg::word_t s;
      mips_pkg::word_t c;
      mips_pkg::word_t e;
      mips_pkg::word_t c1;
      int              e0;
      e0 = errors;
      s  = rand_word();
      c  = rand_word();
      e  = rand_word();
      issue_op(mips_pkg::OPER_MTC0, mips_pkg::FUNC_NONE, s, '0, mips_pkg::CP0_STATUS);
      issue_op(mips_pkg::OPER_MTC0, mips_pkg::FUNC_NONE, c, '0, mips_pkg::CP0_CAUSE);
      issue_op(mips_pkg::OPER_MTC0, mips_pkg::FUNC_NONE, e, '0, mips_pkg::CP0_EPC);
      issue_op(mips_pkg::OPER_MFC0, mips_pkg::FUNC_NONE, '0, '0, mips_pkg::CP0_STATUS);
      check_word("status", s, result);
      issue_op(mips_pkg::OPER_MFC0, mips_pkg::FUNC_NONE, '0, '0, mips_pkg::CP0_CAUSE);
      check_word("cause", c, result);
      issue_op(mips_pkg::OPER_MFC0, mips_pkg::FUNC_NONE, '0, '0, mips_pkg::CP0_EPC);
      check_word("epc", e, result);
      issue_op(mips_pkg::OPER_MFC0, mips_pkg::FUNC_NONE, '0, '0, 5'd3);
      check_word("cp0 reg 3", 32'd0, result);
      issue_op(mips_pkg::OPER_MTC0, mips_pkg::FUNC_NONE, 32'h0000_1000, '0, mips_pkg::CP0_COUNT);
      issue_op(mips_pkg::OPER_MFC0, mips_pkg::FUNC_NONE, '0, '0, mips_pkg::CP0_COUNT);
      check_word("count after write", 32'h0000_1000, result);
      c1 = result;
      repeat (5) issue_op(mips_pkg::OPER_MFC0, mips_pkg::FUNC_NONE, '0, '0, mips_pkg::CP0_COUNT);
      check_word("count delta", 5 * COUNT_STEP, result - c1);
      finish_test("cp0", e0);
   endtask

   initial begin
      #((TEST_CYCLES + MARGIN) * PERIOD);
      $display("ERROR: watchdog expired before the tests completed");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      req        = '0;
      req.oper   = mips_pkg::OPER_NOP;
      lfsr_state = 32'd96;
      exp_hi     = '0;
      exp_lo     = '0;
      checks     = 0;
      errors     = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      test_reset();
      test_logic_shift();
      test_add_sub();
      test_moves();
      test_muldiv();
      test_cp0();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* exec_unit.f */
mips_pkg.sv
sglalu.sv
mulalu.sv
hilo_regs.sv
cp0_regs.sv
exec_unit.sv
tb_exec_unit.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_exec_unit
FILELIST  = exec_unit.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
